// File: files.f
source/ntt_pkg.sv
source/ntt_bf_if.sv
source/ntt_mod_mult.sv
source/ntt_butterfly.sv
source/ntt_operand_router.sv
source/ntt_ready_tracker.sv
source/ntt_bf_2x2.sv
tb/tb_ntt_bf_2x2.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_ntt_bf_2x2 -o tb_ntt_bf_2x2 &&
{
    out="$(./obj_dir/tb_ntt_bf_2x2)"
    printf '%s\n' "$out"
    printf '%s\n' "$out" | grep -q "PASS: all tests"
} &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// File: tb/tb_ntt_bf_2x2.sv
// Self-checking testbench that drives the 2x2 NTT butterfly block as the simulation top
`timescale 1ns/1ps
module tb_ntt_bf_2x2;
    import ntt_pkg::*;

    typedef coeff_t [3:0] quad_t;
    typedef coeff_t [7:0] octet_t;

    localparam int     CLK_PERIOD   = 8;
    localparam int     RESET_CYCLES = 16;
    localparam int     IDLE_CYCLES  = 10;
    localparam int     CT_ITEMS     = 200;
    localparam int     GS_ITEMS     = 200;
    localparam int     PW_ITEMS     = 100;
    localparam int     ZERO_ITEMS   = 30;
    localparam int     EDGE_ITEMS   = 30;
    localparam int     MAX_GAP      = 3;
    localparam int     DRAIN_LIMIT  = 20;
    localparam int     NUM_PHASES   = 12;
    localparam int     TOTAL_ITEMS  = CT_ITEMS + GS_ITEMS + 3 * PW_ITEMS
                                    + 2 * ZERO_ITEMS + 5 * EDGE_ITEMS;
    localparam int     WATCHDOG_NS  = CLK_PERIOD * (RESET_CYCLES + IDLE_CYCLES
                                    + TOTAL_ITEMS * (1 + MAX_GAP)
                                    + NUM_PHASES * (DRAIN_LIMIT + 2));
    localparam longint Q_L          = longint'(NTT_Q);
    // Inverse of 2 mod q
    localparam longint INV2         = (Q_L + 1) / 2;

    logic      clk = 1'b0;
    logic      reset_n;
    logic      zeroize;
    ntt_mode_e mode;
    logic      enable;
    coeff_t    u00, v00, w00, u01, v01, w01, w10, w11;
    quad_t     pw_u, pw_v;
    coeff_t    u20, v20, u21, v21;
    quad_t     pw_res;
    logic      ready;
    int        edge_cnt = 0;

    // Expected results in item order
    quad_t     exp_res_q[$];
    int        exp_edge_q[$];
    bit        exp_pw_q[$];

    ntt_bf_2x2 UUT (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize),
        .mode_i    (mode),
        .enable_i  (enable),
        .u00_i     (u00),
        .v00_i     (v00),
        .w00_i     (w00),
        .u01_i     (u01),
        .v01_i     (v01),
        .w01_i     (w01),
        .w10_i     (w10),
        .w11_i     (w11),
        .pw_u_i    (pw_u),
        .pw_v_i    (pw_v),
        .u20_o     (u20),
        .v20_o     (v20),
        .u21_o     (u21),
        .v21_o     (v21),
        .pw_res_o  (pw_res),
        .ready_o   (ready)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // --------------------
    // Reference model
    // --------------------

    function automatic coeff_t mulq(input coeff_t a, input coeff_t b);
        return coeff_t'((longint'(a) * longint'(b)) % Q_L);
    endfunction

    function automatic coeff_t addq(input coeff_t a, input coeff_t b);
        return coeff_t'((longint'(a) + longint'(b)) % Q_L);
    endfunction

    function automatic coeff_t subq(input coeff_t a, input coeff_t b);
        return coeff_t'((longint'(a) + Q_L - longint'(b)) % Q_L);
    endfunction

    function automatic coeff_t halfq(input coeff_t a);
        return coeff_t'((longint'(a) * INV2) % Q_L);
    endfunction

    // b holds u00, v00, w00, u01, v01, w01, w10, w11 from index 0 up
    function automatic quad_t ref_result(input ntt_mode_e m, input octet_t b,
                                         input quad_t pu, input quad_t pv);
        quad_t  r;
        coeff_t a0, b0, a1, b1;
        int     k;
        r = '0;
        case (m)
            mode_ct: begin
                a0 = addq(b[0], mulq(b[2], b[1]));
                b0 = subq(b[0], mulq(b[2], b[1]));
                a1 = addq(b[3], mulq(b[5], b[4]));
                b1 = subq(b[3], mulq(b[5], b[4]));
                r[0] = addq(a0, mulq(b[6], a1));
                r[1] = subq(a0, mulq(b[6], a1));
                r[2] = addq(b0, mulq(b[7], b1));
                r[3] = subq(b0, mulq(b[7], b1));
            end
            mode_gs: begin
                a0 = halfq(addq(b[0], b[1]));
                b0 = mulq(b[2], halfq(subq(b[0], b[1])));
                a1 = halfq(addq(b[3], b[4]));
                b1 = mulq(b[5], halfq(subq(b[3], b[4])));
                r[0] = halfq(addq(a0, a1));
                r[1] = mulq(b[6], halfq(subq(a0, a1)));
                r[2] = halfq(addq(b0, b1));
                r[3] = mulq(b[7], halfq(subq(b0, b1)));
            end
            default: begin
                for (k = 0; k < 4; k++) begin
                    if (m == mode_pwm) begin
                        r[k] = mulq(pu[k], pv[k]);
                    end else if (m == mode_pwa) begin
                        r[k] = addq(pu[k], pv[k]);
                    end else begin
                        r[k] = subq(pu[k], pv[k]);
                    end
                end
            end
        endcase
        return r;
    endfunction

    // --------------------
    // Error handling
    // --------------------

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input coeff_t got, input coeff_t want);
        assert (got === want) else begin
            $display("** Error %s: got %h expected %h", name, got, want);
            stop_on_error();
        end
    endtask

    // --------------------
    // Comparer
    // --------------------

    // The sampling edge counts as the first latency cycle
    task automatic compare_head();
        quad_t want;
        int    item_edge;
        bit    pw;
        int    lat;
        int    k;
        want      = exp_res_q.pop_front();
        item_edge = exp_edge_q.pop_front();
        pw        = exp_pw_q.pop_front();
        lat       = pw ? PW_LATENCY : BF2X2_LATENCY;
        assert (edge_cnt - item_edge + 1 == lat) else begin
            $display("Result came %0d cycles after its item instead of %0d",
                     edge_cnt - item_edge + 1, lat);
            stop_on_error();
        end
        if (pw) begin
            for (k = 0; k < 4; k++) begin
                check_value($sformatf("pw_res_o[%0d]", k), pw_res[k], want[k]);
            end
        end else begin
            check_value("u20_o", u20, want[0]);
            check_value("v20_o", v20, want[1]);
            check_value("u21_o", u21, want[2]);
            check_value("v21_o", v21, want[3]);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset_n === 1'b1) begin
            assert (ready === 1'b0 || ready === 1'b1) else begin
                $display("ready_o is unknown at edge %0d", edge_cnt);
                stop_on_error();
            end
            if (ready === 1'b1) begin
                assert (exp_res_q.size() != 0) else begin
                    $display("ready_o high with no item in flight at edge %0d", edge_cnt);
                    stop_on_error();
                end
                if (exp_res_q.size() != 0) begin
                    compare_head();
                end
            end
        end
    end

    // --------------------
    // Stimulus
    // --------------------

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic coeff_t pick_coeff(input bit use_edges);
        coeff_t c;
        if (!use_edges) begin
            c = coeff_t'($urandom_range(32'(NTT_Q) - 32'd1, 32'd0));
        end else begin
            case ($urandom_range(2, 0))
                0:       c = '0;
                1:       c = coeff_t'(1);
                default: c = NTT_Q - coeff_t'(1);
            endcase
        end
        return c;
    endfunction

    task automatic drive_item(input bit use_edges);
        octet_t b;
        quad_t  pu;
        quad_t  pv;
        int     k;
        for (k = 0; k < 8; k++) begin
            b[k] = pick_coeff(use_edges);
        end
        for (k = 0; k < 4; k++) begin
            pu[k] = pick_coeff(use_edges);
            pv[k] = pick_coeff(use_edges);
        end
        {w11, w10, w01, v01, u01, w00, v00, u00} = b;
        pw_u   = pu;
        pw_v   = pv;
        enable = 1'b1;
        exp_res_q.push_back(ref_result(mode, b, pu, pv));
        exp_edge_q.push_back(edge_cnt + 1);
        exp_pw_q.push_back(mode inside {mode_pwm, mode_pwa, mode_pws});
    endtask

    task automatic run_stream(input ntt_mode_e m, input int n, input int max_gap,
                              input bit use_edges);
        int i;
        int gap;
        next_cycle();
        mode = m;
        for (i = 0; i < n; i++) begin
            drive_item(use_edges);
            next_cycle();
            enable = 1'b0;
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) next_cycle();
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_res_q.size() != 0 && n < DRAIN_LIMIT) begin
            next_cycle();
            n++;
        end
        assert (exp_res_q.size() == 0) else begin
            $display("%0d items never produced ready_o", exp_res_q.size());
            stop_on_error();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns without finishing the tests", WATCHDOG_NS);
        stop_on_error();
    end

    initial begin
        reset_n = 1'b0;
        zeroize = 1'b0;
        mode    = mode_ct;
        enable  = 1'b0;
        {w11, w10, w01, v01, u01, w00, v00, u00} = '0;
        pw_u    = '0;
        pw_v    = '0;
        void'($urandom(32'h40ea));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;

        // Idle after reset so any ready_o pulse is flagged
        repeat (IDLE_CYCLES) next_cycle();

        run_stream(mode_ct, CT_ITEMS, 0, 1'b0);
        drain();
        run_stream(mode_gs, GS_ITEMS, MAX_GAP, 1'b0);
        drain();
        run_stream(mode_pwm, PW_ITEMS, 1, 1'b0);
        drain();
        run_stream(mode_pwa, PW_ITEMS, 1, 1'b0);
        drain();
        run_stream(mode_pws, PW_ITEMS, 1, 1'b0);
        drain();

        // Zeroize drops the CT items still in flight
        run_stream(mode_ct, ZERO_ITEMS, 0, 1'b0);
        zeroize = 1'b1;
        next_cycle();
        zeroize = 1'b0;
        exp_res_q.delete();
        exp_edge_q.delete();
        exp_pw_q.delete();
        run_stream(mode_ct, ZERO_ITEMS, 2, 1'b0);
        drain();

        // Operands drawn from 0, 1 and q-1
        run_stream(mode_ct, EDGE_ITEMS, 1, 1'b1);
        drain();
        run_stream(mode_gs, EDGE_ITEMS, 1, 1'b1);
        drain();
        run_stream(mode_pwm, EDGE_ITEMS, 1, 1'b1);
        drain();
        run_stream(mode_pwa, EDGE_ITEMS, 1, 1'b1);
        drain();
        run_stream(mode_pws, EDGE_ITEMS, 1, 1'b1);

        repeat (IDLE_CYCLES) next_cycle();
        if (exp_res_q.size() != 0) begin
            $display("%0d items left over at the end", exp_res_q.size());
            $display("FAIL: see errors above");
            $fatal(1, "Items left over");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: source/ntt_bf_2x2.sv
// Top level of the 2x2 NTT butterfly block, two stages of two units plus ready tracking
`timescale 1ns/1ps
module ntt_bf_2x2 (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  ntt_pkg::ntt_mode_e    mode_i,
    input  logic                  enable_i,
    input  ntt_pkg::coeff_t       u00_i,
    input  ntt_pkg::coeff_t       v00_i,
    input  ntt_pkg::coeff_t       w00_i,
    input  ntt_pkg::coeff_t       u01_i,
    input  ntt_pkg::coeff_t       v01_i,
    input  ntt_pkg::coeff_t       w01_i,
    input  ntt_pkg::coeff_t       w10_i,
    input  ntt_pkg::coeff_t       w11_i,
    input  ntt_pkg::coeff_t [3:0] pw_u_i,
    input  ntt_pkg::coeff_t [3:0] pw_v_i,
    output ntt_pkg::coeff_t       u20_o,
    output ntt_pkg::coeff_t       v20_o,
    output ntt_pkg::coeff_t       u21_o,
    output ntt_pkg::coeff_t       v21_o,
    output ntt_pkg::coeff_t [3:0] pw_res_o,
    output logic                  ready_o
);

    // One bundle per butterfly unit
    ntt_bf_if bf00_if ();
    ntt_bf_if bf01_if ();
    ntt_bf_if bf10_if ();
    ntt_bf_if bf11_if ();

    // --------------------
    // Operand routing
    // --------------------

    ntt_operand_router router_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .u00_i     (u00_i),
        .v00_i     (v00_i),
        .w00_i     (w00_i),
        .u01_i     (u01_i),
        .v01_i     (v01_i),
        .w01_i     (w01_i),
        .w10_i     (w10_i),
        .w11_i     (w11_i),
        .pw_u_i    (pw_u_i),
        .pw_v_i    (pw_v_i),
        .bf00      (bf00_if),
        .bf01      (bf01_if),
        .bf10      (bf10_if),
        .bf11      (bf11_if),
        .u20_o     (u20_o),
        .v20_o     (v20_o),
        .u21_o     (u21_o),
        .v21_o     (v21_o),
        .pw_res_o  (pw_res_o)
    );

    // --------------------
    // Butterfly units
    // --------------------

    // Stage 1
    ntt_butterfly bf_inst00 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .bf        (bf00_if)
    );

    ntt_butterfly bf_inst01 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .bf        (bf01_if)
    );

    // Stage 2, also units 2 and 3 in pointwise modes
    ntt_butterfly bf_inst10 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .bf        (bf10_if)
    );

    ntt_butterfly bf_inst11 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .bf        (bf11_if)
    );

    ntt_ready_tracker ready_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .enable_i  (enable_i),
        .ready_o   (ready_o)
    );

endmodule

// File: source/ntt_ready_tracker.sv
// Enable delay line that raises ready_o once an item has crossed the butterfly pipeline
`timescale 1ns/1ps
module ntt_ready_tracker (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  ntt_pkg::ntt_mode_e mode_i,
    input  logic               enable_i,
    output logic               ready_o
);
    import ntt_pkg::*;

    logic                     pw_mode;
    logic [BF2X2_LATENCY-1:0] ready_q;

    assign pw_mode = mode_i inside {mode_pwm, mode_pwa, mode_pws};

    // Enable enters at the tap matching the mode latency and shifts down to bit 0
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            ready_q <= '0;
        end else if (pw_mode) begin
            ready_q <= {{(BF2X2_LATENCY-PW_LATENCY){1'b0}}, enable_i,
                        ready_q[PW_LATENCY-1:1]};
        end else begin
            ready_q <= {enable_i, ready_q[BF2X2_LATENCY-1:1]};
        end
    end

    assign ready_o = ready_q[0];

    // Units decode mode_i every cycle, so items in flight need a steady mode
    a_mode_steady: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (|ready_q) |-> $stable(mode_i))
        else $error("ntt_ready_tracker: mode_i changed with items in flight");

endmodule

// File: source/ntt_operand_router.sv
// Selects butterfly operands per mode and feeds stage-1 results and delayed twiddles to stage 2
`timescale 1ns/1ps
module ntt_operand_router (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  ntt_pkg::ntt_mode_e    mode_i,
    input  ntt_pkg::coeff_t       u00_i,
    input  ntt_pkg::coeff_t       v00_i,
    input  ntt_pkg::coeff_t       w00_i,
    input  ntt_pkg::coeff_t       u01_i,
    input  ntt_pkg::coeff_t       v01_i,
    input  ntt_pkg::coeff_t       w01_i,
    input  ntt_pkg::coeff_t       w10_i,
    input  ntt_pkg::coeff_t       w11_i,
    input  ntt_pkg::coeff_t [3:0] pw_u_i,
    input  ntt_pkg::coeff_t [3:0] pw_v_i,
    ntt_bf_if.router              bf00,
    ntt_bf_if.router              bf01,
    ntt_bf_if.router              bf10,
    ntt_bf_if.router              bf11,
    output ntt_pkg::coeff_t       u20_o,
    output ntt_pkg::coeff_t       v20_o,
    output ntt_pkg::coeff_t       u21_o,
    output ntt_pkg::coeff_t       v21_o,
    output ntt_pkg::coeff_t [3:0] pw_res_o
);
    import ntt_pkg::*;

    logic                     pw_mode;
    coeff_t [BF_LATENCY-1:0]  w10_dly_q;
    coeff_t [BF_LATENCY-1:0]  w11_dly_q;

    assign pw_mode = mode_i inside {mode_pwm, mode_pwa, mode_pws};

    // --------------------
    // Twiddle delay
    // --------------------

    // Stage-2 twiddles wait out the stage-1 latency
    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            w10_dly_q <= '0;
            w11_dly_q <= '0;
        end else begin
            w10_dly_q <= {w10_dly_q[BF_LATENCY-2:0], w10_i};
            w11_dly_q <= {w11_dly_q[BF_LATENCY-2:0], w11_i};
        end
    end

    // --------------------
    // Operand select
    // --------------------

    always_comb begin
        if (pw_mode) begin
            // Each unit works on its own coefficient pair
            bf00.opu = pw_u_i[0];
            bf00.opv = pw_v_i[0];
            bf00.opw = '0;
            bf01.opu = pw_u_i[1];
            bf01.opv = pw_v_i[1];
            bf01.opw = '0;
            bf10.opu = pw_u_i[2];
            bf10.opv = pw_v_i[2];
            bf10.opw = '0;
            bf11.opu = pw_u_i[3];
            bf11.opv = pw_v_i[3];
            bf11.opw = '0;
        end else begin
            bf00.opu = u00_i;
            bf00.opv = v00_i;
            bf00.opw = w00_i;
            bf01.opu = u01_i;
            bf01.opv = v01_i;
            bf01.opw = w01_i;
            // Cross the stage-1 outputs into stage 2
            bf10.opu = bf00.res_u;
            bf10.opv = bf01.res_u;
            bf10.opw = w10_dly_q[BF_LATENCY-1];
            bf11.opu = bf00.res_v;
            bf11.opv = bf01.res_v;
            bf11.opw = w11_dly_q[BF_LATENCY-1];
        end
    end

    assign u20_o = bf10.res_u;
    assign v20_o = bf10.res_v;
    assign u21_o = bf11.res_u;
    assign v21_o = bf11.res_v;

    assign pw_res_o = {bf11.res_pw, bf10.res_pw, bf01.res_pw, bf00.res_pw};

endmodule

// File: source/ntt_butterfly.sv
// One butterfly unit for CT, GS and pointwise ops, four cycles from operands to results
`timescale 1ns/1ps
module ntt_butterfly (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               zeroize_i,
    input  ntt_pkg::ntt_mode_e mode_i,
    ntt_bf_if.unit             bf
);
    import ntt_pkg::*;

    logic                       ct_mode;
    logic                       gs_mode;
    logic                       pwm_mode;
    coeff_t                     u_sum;
    coeff_t                     u_diff;
    coeff_t                     first_val;
    coeff_t [MULT_LATENCY-1:0]  u_dly_q;
    coeff_t                     half_diff_q;
    coeff_t                     w_q;
    coeff_t                     mult_a;
    coeff_t                     mult_b;
    coeff_t                     prod;
    coeff_t                     res_u_q;
    coeff_t                     res_v_q;

    // --------------------
    // Mod q helpers
    // --------------------

    function automatic coeff_t add_mod(coeff_t a, coeff_t b);
        logic [COEFF_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, NTT_Q}) begin
            sum = sum - {1'b0, NTT_Q};
        end
        return sum[COEFF_W-1:0];
    endfunction

    function automatic coeff_t sub_mod(coeff_t a, coeff_t b);
        logic [COEFF_W:0] diff;
        diff = {1'b0, a} - {1'b0, b};
        // Wrap back into range on borrow
        if (a < b) begin
            diff = diff + {1'b0, NTT_Q};
        end
        return diff[COEFF_W-1:0];
    endfunction

    // Odd values get q added so the shift is exact
    function automatic coeff_t half_mod(coeff_t x);
        logic [COEFF_W:0] t;
        t = {1'b0, x};
        if (x[0]) begin
            t = t + {1'b0, NTT_Q};
        end
        return t[COEFF_W:1];
    endfunction

    assign ct_mode  = (mode_i == mode_ct);
    assign gs_mode  = (mode_i == mode_gs);
    assign pwm_mode = (mode_i == mode_pwm);

    assign u_sum  = add_mod(bf.opu, bf.opv);
    assign u_diff = sub_mod(bf.opu, bf.opv);

    // Value that travels down the delay line beside the multiplier
    always_comb begin
        case (mode_i)
            mode_ct:  first_val = bf.opu;
            mode_gs:  first_val = half_mod(u_sum);
            mode_pws: first_val = u_diff;
            default:  first_val = u_sum;
        endcase
    end

    // GS multiplies the registered half difference, others use raw operands
    assign mult_a = gs_mode ? half_diff_q : (pwm_mode ? bf.opu : bf.opv);
    assign mult_b = gs_mode ? w_q : (pwm_mode ? bf.opv : bf.opw);

    ntt_mod_mult mult_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mult_a),
        .b_i       (mult_b),
        .p_o       (prod)
    );

    // --------------------
    // Pipeline registers
    // --------------------

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            u_dly_q     <= '0;
            half_diff_q <= '0;
            w_q         <= '0;
            res_u_q     <= '0;
            res_v_q     <= '0;
        end else begin
            u_dly_q     <= {u_dly_q[MULT_LATENCY-2:0], first_val};
            half_diff_q <= half_mod(u_diff);
            w_q         <= bf.opw;
            // Final stage: CT add, pwm product, otherwise the delayed value
            if (ct_mode) begin
                res_u_q <= add_mod(u_dly_q[MULT_LATENCY-1], prod);
            end else if (pwm_mode) begin
                res_u_q <= prod;
            end else begin
                res_u_q <= u_dly_q[MULT_LATENCY-1];
            end
            res_v_q <= sub_mod(u_dly_q[MULT_LATENCY-1], prod);
        end
    end

    // GS product already lands on the fourth edge
    assign bf.res_u  = res_u_q;
    assign bf.res_v  = gs_mode ? prod : res_v_q;
    // Pointwise result shares the u register
    assign bf.res_pw = res_u_q;

    // Upstream stages and the block inputs must deliver reduced operands
    a_operands_reduced: assert property (@(posedge clk) disable iff (!reset_n)
        bf.opu < NTT_Q && bf.opv < NTT_Q && bf.opw < NTT_Q)
        else $error("ntt_butterfly: operand not below q");

endmodule

// File: source/ntt_mod_mult.sv
// Three-stage modular multiplier mod q, instantiated once inside every butterfly unit
`timescale 1ns/1ps
module ntt_mod_mult (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  ntt_pkg::coeff_t a_i,
    input  ntt_pkg::coeff_t b_i,
    output ntt_pkg::coeff_t p_o
);
    import ntt_pkg::*;

    logic [2*COEFF_W-1:0] prod_q;
    logic [COEFF_W-1:0]   hi;
    logic [27:0]          fold1;
    logic [23:0]          fold2;
    logic [23:0]          red_q;
    coeff_t               p_q;

    // --------------------
    // Fold logic
    // --------------------

    assign hi = prod_q[2*COEFF_W-1:COEFF_W];

    // 2^23 = 2^13 - 1 mod q, applied to hi and again to its top 13 bits
    // Adding 2q keeps the result non-negative
    assign fold1 = 28'(prod_q[COEFF_W-1:0])
                 + ((28'(hi[9:0]) + 28'(hi[22:10])) << 13)
                 + 28'(2 * NTT_Q)
                 - 28'(hi[22:10])
                 - 28'(hi);

    // fold1 stays below 2^27 so the top part is tiny
    // Result is below 2q after this fold
    assign fold2 = 24'(fold1[22:0])
                 + (24'(fold1[27:23]) << 13)
                 - 24'(fold1[27:23]);

    // --------------------
    // Pipeline
    // --------------------

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            prod_q <= '0;
            red_q  <= '0;
            p_q    <= '0;
        end else begin
            prod_q <= a_i * b_i;
            red_q  <= fold2;
            if (red_q >= 24'(NTT_Q)) begin
                p_q <= coeff_t'(red_q - 24'(NTT_Q));
            end else begin
                p_q <= red_q[COEFF_W-1:0];
            end
        end
    end

    assign p_o = p_q;

    // Folding must leave less than 2q for the single subtraction
    a_p_reduced: assert property (@(posedge clk) disable iff (!reset_n) p_o < NTT_Q)
        else $error("ntt_mod_mult: product not reduced below q");

endmodule

// File: source/ntt_bf_if.sv
// Operand and result bundle between the operand router and one butterfly unit
`timescale 1ns/1ps
interface ntt_bf_if;
    import ntt_pkg::*;

    // Operands sampled by the unit on every clock
    coeff_t opu;
    coeff_t opv;
    coeff_t opw;

    // Results appear BF_LATENCY cycles after their operands
    coeff_t res_u;
    coeff_t res_v;
    coeff_t res_pw;

    // Router side drives operands and collects results
    modport router (
        output opu, opv, opw,
        input  res_u, res_v, res_pw
    );

    // Unit side
    modport unit (
        input  opu, opv, opw,
        output res_u, res_v, res_pw
    );

endinterface

// File: source/ntt_pkg.sv
// Modulus, widths, latencies, mode encoding and coefficient type shared by the NTT butterfly RTL
package ntt_pkg;

    // --------------------
    // Arithmetic
    // --------------------

    localparam int COEFF_W = 23;

    // ML-DSA prime, 2^23 - 2^13 + 1
    localparam logic [COEFF_W-1:0] NTT_Q = 23'd8380417;

    // One coefficient, always kept below NTT_Q
    typedef logic [COEFF_W-1:0] coeff_t;

    // --------------------
    // Pipeline depths
    // --------------------

    // Product register, fold, final subtraction
    localparam int MULT_LATENCY = 3;

    // Multiplier plus one add/sub or input stage
    localparam int BF_LATENCY = MULT_LATENCY + 1;

    // Two butterfly stages back to back
    localparam int BF2X2_LATENCY = 2 * BF_LATENCY;

    // Pointwise ops use a single unit
    localparam int PW_LATENCY = BF_LATENCY;

    // --------------------
    // Operation modes
    // --------------------

    // ct is the forward NTT, gs the inverse, pw* are pointwise
    typedef enum logic [2:0] {
        mode_ct,
        mode_gs,
        mode_pwm,
        mode_pwa,
        mode_pws
    } ntt_mode_e;

endpackage
